// ==== design/decode.sv ====
// Decode stage of rv_core: takes fetched words, decodes them and stalls on register hazards
`timescale 1ns/100ps
module decode import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              fetch_valid_i,
  input  logic [XLEN-1:0]   fetch_instr_i,
  output logic              fetch_ready_o,
  input  logic              jump_i,
  input  logic [XLEN-1:0]   jump_pc_i,
  input  logic [REG_AW-1:0] ex_rd_i,
  input  logic              ex_we_i,
  input  logic [REG_AW-1:0] wb_rd_i,
  input  logic [XLEN-1:0]   wb_data_i,
  input  logic              wb_we_i,
  output logic              id_valid_o,
  output logic [XLEN-1:0]   id_pc_o,
  output logic [REG_AW-1:0] id_rd_o,
  output logic              id_we_o,
  output logic [XLEN-1:0]   id_rs1_data_o,
  output logic [XLEN-1:0]   id_rs2_data_o,
  output logic [XLEN-1:0]   id_imm_o,
  output opsel_t            id_op1_sel_o,
  output opsel_t            id_op2_sel_o,
  output alu_op_t           id_alu_op_o,
  output logic [2:0]        id_f3_o,
  output xfer_t             id_xfer_o,
  output logic              id_trap_o,
  input  logic              id_ready_i
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [REG_AW-1:0] rd_addr;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   imm_j;
  logic [XLEN-1:0]   imm_b;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              hazard_id;
  logic              hazard_ex;
  logic              fetch_xfer;
  logic [XLEN-1:0]   fetch_pc_q;
  alu_op_t           alu_f3;
  opsel_t            dec_op1_sel;
  opsel_t            dec_op2_sel;
  alu_op_t           dec_alu_op;
  xfer_t             dec_xfer;
  logic              dec_we;
  logic              dec_trap;
  logic [XLEN-1:0]   dec_imm;

  assign opcode   = fetch_instr_i[6:0];
  assign rd_addr  = fetch_instr_i[11:7];
  assign funct3   = fetch_instr_i[14:12];
  assign rs1_addr = fetch_instr_i[19:15];
  assign rs2_addr = fetch_instr_i[24:20];

  assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
  assign imm_u = {fetch_instr_i[31:12], 12'b0};
  assign imm_j = {{12{fetch_instr_i[31]}}, fetch_instr_i[19:12], fetch_instr_i[20],
                  fetch_instr_i[30:21], 1'b0};
  assign imm_b = {{20{fetch_instr_i[31]}}, fetch_instr_i[7], fetch_instr_i[30:25],
                  fetch_instr_i[11:8], 1'b0};

  // Bit 30 selects SUB only for register-register ops
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_f3 = (opcode == OPC_OP && fetch_instr_i[30]) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_f3 = ALU_SLL;
      F3_SLT:     alu_f3 = ALU_SLT;
      F3_SLTU:    alu_f3 = ALU_SLTU;
      F3_XOR:     alu_f3 = ALU_XOR;
      F3_SR:      alu_f3 = fetch_instr_i[30] ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_f3 = ALU_OR;
      default:    alu_f3 = ALU_AND;
    endcase
  end

  always_comb begin
    dec_op1_sel = OPSEL_REG;
    dec_op2_sel = OPSEL_IMM;
    dec_alu_op  = ALU_ADD;
    dec_xfer    = XFER_NONE;
    dec_we      = 1'b1;
    dec_trap    = 1'b0;
    dec_imm     = imm_i;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec_op2_sel = OPSEL_REG;
        dec_alu_op  = alu_f3;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_alu_op = alu_f3;
        uses_rs1   = 1'b1;
      end
      OPC_LUI: begin
        dec_op1_sel = OPSEL_ZERO;
        dec_imm     = imm_u;
      end
      OPC_AUIPC: begin
        dec_op1_sel = OPSEL_PC;
        dec_imm     = imm_u;
      end
      OPC_JAL: begin
        dec_xfer = XFER_JAL;
        dec_imm  = imm_j;
      end
      OPC_JALR: begin
        dec_xfer = XFER_JALR;
        uses_rs1 = 1'b1;
      end
      OPC_BRANCH: begin
        dec_op2_sel = OPSEL_REG;
        dec_xfer    = XFER_BRANCH;
        dec_we      = 1'b0;
        dec_imm     = imm_b;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        // funct3 010 and 011 are not branch conditions
        if (funct3[2:1] == 2'b01) begin
          dec_xfer = XFER_NONE;
          dec_trap = 1'b1;
        end
      end
      default: begin
        dec_we   = 1'b0;
        dec_trap = 1'b1;
      end
    endcase
    // Trapped word rides to writeback in the immediate field
    if (dec_trap) begin
      dec_imm = fetch_instr_i;
    end
  end

  // Wait until producers in decode or execute have written the register file
  assign hazard_id = id_valid_o && id_we_o && (id_rd_o != '0) &&
                     ((uses_rs1 && id_rd_o == rs1_addr) || (uses_rs2 && id_rd_o == rs2_addr));
  assign hazard_ex = ex_we_i && (ex_rd_i != '0) &&
                     ((uses_rs1 && ex_rd_i == rs1_addr) || (uses_rs2 && ex_rd_i == rs2_addr));

  assign fetch_ready_o = id_ready_i && !hazard_id && !hazard_ex && !jump_i;
  assign fetch_xfer    = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_valid_o <= 1'b0;
      fetch_pc_q <= RESET_PC;
    end else if (jump_i) begin
      id_valid_o <= 1'b0;
      fetch_pc_q <= jump_pc_i;
    end else begin
      if (id_ready_i) begin
        id_valid_o <= fetch_xfer;
      end
      if (fetch_xfer) begin
        fetch_pc_q <= fetch_pc_q + XLEN'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      id_pc_o      <= fetch_pc_q;
      id_rd_o      <= rd_addr;
      id_we_o      <= dec_we;
      id_imm_o     <= dec_imm;
      id_op1_sel_o <= dec_op1_sel;
      id_op2_sel_o <= dec_op2_sel;
      id_alu_op_o  <= dec_alu_op;
      id_f3_o      <= funct3;
      id_xfer_o    <= dec_xfer;
      id_trap_o    <= dec_trap;
    end
  end

  register_file u_register_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .re_i       (fetch_xfer),
    .rd_addr_i  (wb_rd_i),
    .rd_data_i  (wb_data_i),
    .we_i       (wb_we_i),
    .rs1_data_o (id_rs1_data_o),
    .rs2_data_o (id_rs2_data_o)
  );

endmodule

// ==== design/execute.sv ====
// Execute stage of rv_core: ALU, branch resolution and redirect, registered toward writeback
`timescale 1ns/100ps
module execute import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              id_valid_i,
  input  logic [XLEN-1:0]   id_pc_i,
  input  logic [REG_AW-1:0] id_rd_i,
  input  logic              id_we_i,
  input  logic [XLEN-1:0]   id_rs1_data_i,
  input  logic [XLEN-1:0]   id_rs2_data_i,
  input  logic [XLEN-1:0]   id_imm_i,
  input  opsel_t            id_op1_sel_i,
  input  opsel_t            id_op2_sel_i,
  input  alu_op_t           id_alu_op_i,
  input  logic [2:0]        id_f3_i,
  input  xfer_t             id_xfer_i,
  input  logic              id_trap_i,
  output logic              ex_ready_o,
  output logic              jump_o,
  output logic [XLEN-1:0]   jump_pc_o,
  output logic              ex_valid_o,
  output logic [XLEN-1:0]   ex_pc_o,
  output logic [REG_AW-1:0] ex_rd_o,
  output logic              ex_we_o,
  output logic [XLEN-1:0]   ex_result_o,
  output logic              ex_trap_o,
  input  logic              ex_ready_i
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] result;
  logic            lt_s;
  logic            lt_u;
  logic            cond;
  logic            accept;

  function automatic logic [XLEN-1:0] pick(input opsel_t sel, input logic [XLEN-1:0] rs,
                                           input logic [XLEN-1:0] imm,
                                           input logic [XLEN-1:0] pc);
    case (sel)
      OPSEL_REG: return rs;
      OPSEL_IMM: return imm;
      OPSEL_PC:  return pc;
      default:   return '0;
    endcase
  endfunction

  assign op_a = pick(id_op1_sel_i, id_rs1_data_i, id_imm_i, id_pc_i);
  assign op_b = pick(id_op2_sel_i, id_rs2_data_i, id_imm_i, id_pc_i);
  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (id_alu_op_i)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = XLEN'(lt_s);
      ALU_SLTU: alu_res = XLEN'(lt_u);
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b;
    endcase
  end

  // Branch operands come through both register selects
  always_comb begin
    case (id_f3_i)
      F3_BEQ:  cond = op_a == op_b;
      F3_BNE:  cond = op_a != op_b;
      F3_BLT:  cond = lt_s;
      F3_BGE:  cond = !lt_s;
      F3_BLTU: cond = lt_u;
      F3_BGEU: cond = !lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign ex_ready_o = !ex_valid_o || ex_ready_i;
  assign accept     = id_valid_i && ex_ready_o;

  assign target    = ((id_xfer_i == XFER_JALR) ? id_rs1_data_i : id_pc_i) + id_imm_i;
  assign jump_pc_o = {target[XLEN-1:1], target[0] && (id_xfer_i != XFER_JALR)};
  assign jump_o    = accept && ((id_xfer_i == XFER_JAL) || (id_xfer_i == XFER_JALR) ||
                                (id_xfer_i == XFER_BRANCH && cond));

  always_comb begin
    if (id_trap_i) begin
      result = id_imm_i;
    end else if (id_xfer_i == XFER_JAL || id_xfer_i == XFER_JALR) begin
      result = id_pc_i + XLEN'(4);
    end else begin
      result = alu_res;
    end
  end

  // Write enable is cleared when empty so the hazard check can trust it
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
    end else if (ex_ready_o) begin
      ex_valid_o <= id_valid_i;
      ex_we_o    <= id_valid_i && id_we_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_pc_o     <= id_pc_i;
      ex_rd_o     <= id_rd_i;
      ex_result_o <= result;
      ex_trap_o   <= id_trap_i;
    end
  end

endmodule

// ==== design/register_file.sv ====
// 32x32 integer register file with registered reads, used inside the decode stage
`timescale 1ns/100ps
module register_file import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic [REG_AW-1:0] rs1_addr_i,
  input  logic [REG_AW-1:0] rs2_addr_i,
  input  logic              re_i,
  input  logic [REG_AW-1:0] rd_addr_i,
  input  logic [XLEN-1:0]   rd_data_i,
  input  logic              we_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o
);

  logic [XLEN-1:0] regs [2**REG_AW];
  logic            wr_en;

  // x0 is never written, so it keeps reading zero
  assign wr_en = we_i && (rd_addr_i != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
      rs1_data_o <= '0;
      rs2_data_o <= '0;
    end else begin
      if (wr_en) begin
        regs[rd_addr_i] <= rd_data_i;
      end
      if (re_i) begin
        // Same-edge write is passed straight to the read port
        rs1_data_o <= (wr_en && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
        rs2_data_o <= (wr_en && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];
      end
    end
  end

endmodule

// ==== design/rv_core.sv ====
// Top level of the three-stage RV32I slice; the fetch source and retire sink sit outside
`timescale 1ns/100ps
module rv_core import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              fetch_valid_i,
  input  logic [XLEN-1:0]   fetch_instr_i,
  output logic              fetch_ready_o,
  output logic              jump_o,
  output logic [XLEN-1:0]   jump_pc_o,
  output logic              retire_valid_o,
  output logic [XLEN-1:0]   retire_pc_o,
  output logic [REG_AW-1:0] retire_rd_o,
  output logic              retire_we_o,
  output logic [XLEN-1:0]   retire_data_o,
  output logic              retire_trap_o,
  input  logic              retire_ready_i
);

  logic              id_valid;
  logic [XLEN-1:0]   id_pc;
  logic [REG_AW-1:0] id_rd;
  logic              id_we;
  logic [XLEN-1:0]   id_rs1_data;
  logic [XLEN-1:0]   id_rs2_data;
  logic [XLEN-1:0]   id_imm;
  opsel_t            id_op1_sel;
  opsel_t            id_op2_sel;
  alu_op_t           id_alu_op;
  logic [2:0]        id_f3;
  xfer_t             id_xfer;
  logic              id_trap;
  logic              ex_ready;
  logic              ex_valid;
  logic [XLEN-1:0]   ex_pc;
  logic [REG_AW-1:0] ex_rd;
  logic              ex_we;
  logic [XLEN-1:0]   ex_result;
  logic              ex_trap;
  logic              wb_ready;
  logic [REG_AW-1:0] rf_rd;
  logic [XLEN-1:0]   rf_data;
  logic              rf_we;

  decode u_decode (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .jump_i        (jump_o),
    .jump_pc_i     (jump_pc_o),
    .ex_rd_i       (ex_rd),
    .ex_we_i       (ex_we),
    .wb_rd_i       (rf_rd),
    .wb_data_i     (rf_data),
    .wb_we_i       (rf_we),
    .id_valid_o    (id_valid),
    .id_pc_o       (id_pc),
    .id_rd_o       (id_rd),
    .id_we_o       (id_we),
    .id_rs1_data_o (id_rs1_data),
    .id_rs2_data_o (id_rs2_data),
    .id_imm_o      (id_imm),
    .id_op1_sel_o  (id_op1_sel),
    .id_op2_sel_o  (id_op2_sel),
    .id_alu_op_o   (id_alu_op),
    .id_f3_o       (id_f3),
    .id_xfer_o     (id_xfer),
    .id_trap_o     (id_trap),
    .id_ready_i    (ex_ready)
  );

  execute u_execute (
    .clk           (clk),
    .rst_i         (rst_i),
    .id_valid_i    (id_valid),
    .id_pc_i       (id_pc),
    .id_rd_i       (id_rd),
    .id_we_i       (id_we),
    .id_rs1_data_i (id_rs1_data),
    .id_rs2_data_i (id_rs2_data),
    .id_imm_i      (id_imm),
    .id_op1_sel_i  (id_op1_sel),
    .id_op2_sel_i  (id_op2_sel),
    .id_alu_op_i   (id_alu_op),
    .id_f3_i       (id_f3),
    .id_xfer_i     (id_xfer),
    .id_trap_i     (id_trap),
    .ex_ready_o    (ex_ready),
    .jump_o        (jump_o),
    .jump_pc_o     (jump_pc_o),
    .ex_valid_o    (ex_valid),
    .ex_pc_o       (ex_pc),
    .ex_rd_o       (ex_rd),
    .ex_we_o       (ex_we),
    .ex_result_o   (ex_result),
    .ex_trap_o     (ex_trap),
    .ex_ready_i    (wb_ready)
  );

  writeback u_writeback (
    .clk            (clk),
    .rst_i          (rst_i),
    .ex_valid_i     (ex_valid),
    .ex_pc_i        (ex_pc),
    .ex_rd_i        (ex_rd),
    .ex_we_i        (ex_we),
    .ex_result_i    (ex_result),
    .ex_trap_i      (ex_trap),
    .wb_ready_o     (wb_ready),
    .rf_rd_o        (rf_rd),
    .rf_data_o      (rf_data),
    .rf_we_o        (rf_we),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_data_o  (retire_data_o),
    .retire_ready_i (retire_ready_i),
    .retire_trap_o  (retire_trap_o)
  );

endmodule

// ==== design/rv_core_pkg.sv ====
// Shared widths, RV32I opcode and funct3 codes and decode enums, imported by every rv_core module
package rv_core_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // ALU funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [1:0] {
    OPSEL_REG  = 2'd0,
    OPSEL_IMM  = 2'd1,
    OPSEL_PC   = 2'd2,
    OPSEL_ZERO = 2'd3
  } opsel_t;

  // funct7 bit 30 is already folded in here
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    XFER_NONE   = 2'd0,
    XFER_JAL    = 2'd1,
    XFER_JALR   = 2'd2,
    XFER_BRANCH = 2'd3
  } xfer_t;

endpackage

// ==== design/writeback.sv ====
// Writeback stage of rv_core: writes the register file and holds the retire record
`timescale 1ns/100ps
module writeback import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              ex_valid_i,
  input  logic [XLEN-1:0]   ex_pc_i,
  input  logic [REG_AW-1:0] ex_rd_i,
  input  logic              ex_we_i,
  input  logic [XLEN-1:0]   ex_result_i,
  input  logic              ex_trap_i,
  output logic              wb_ready_o,
  output logic [REG_AW-1:0] rf_rd_o,
  output logic [XLEN-1:0]   rf_data_o,
  output logic              rf_we_o,
  output logic              retire_valid_o,
  output logic [XLEN-1:0]   retire_pc_o,
  output logic [REG_AW-1:0] retire_rd_o,
  output logic              retire_we_o,
  output logic [XLEN-1:0]   retire_data_o,
  input  logic              retire_ready_i,
  output logic              retire_trap_o
);

  logic accept;

  assign wb_ready_o = !retire_valid_o || retire_ready_i;
  assign accept     = ex_valid_i && wb_ready_o;

  // Register file is updated on the accepting edge
  assign rf_rd_o   = ex_rd_i;
  assign rf_data_o = ex_result_i;
  assign rf_we_o   = accept && ex_we_i && (ex_rd_i != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      retire_valid_o <= 1'b0;
    end else if (wb_ready_o) begin
      retire_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc_o   <= ex_pc_i;
      retire_rd_o   <= ex_rd_i;
      retire_we_o   <= ex_we_i;
      retire_data_o <= ex_result_i;
      retire_trap_o <= ex_trap_i;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the rv_core testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_core -f rv_core.f -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1

// ==== rv_core.f ====
+incdir+tests
design/rv_core_pkg.sv
design/register_file.sv
design/decode.sv
design/execute.sv
design/writeback.sv
design/rv_core.sv
tests/tb_rv_core.sv

// ==== tests/tb_program.svh ====
// Program image and expected retire sequence, included inside the rv_core testbench module
// PROG columns: instruction word at byte address 4*index, with its assembly in the comment
// EXP columns: {pc, rd, we, data, trap}; rd is checked only when we is set,
// and data only when we or trap is set

localparam int PROG_LEN = 25;
localparam int RET_LEN  = 22;

localparam logic [XLEN-1:0] PROG [PROG_LEN] = '{
  32'h0050_0093,  // 00 addi x1, x0, 5
  32'h8000_0137,  // 04 lui  x2, 0x80000
  32'h0000_1197,  // 08 auipc x3, 0x1
  32'h4020_8233,  // 0c sub  x4, x1, x2
  32'h4011_52b3,  // 10 sra  x5, x2, x1
  32'h0012_2333,  // 14 slt  x6, x4, x1
  32'h0042_f3b3,  // 18 and  x7, x5, x4
  32'h0070_8013,  // 1c addi x0, x1, 7
  32'h0010_0433,  // 20 add  x8, x0, x1
  32'h0014_0493,  // 24 addi x9, x8, 1
  32'h0024_8493,  // 28 addi x9, x9, 2
  32'h0094_8533,  // 2c add  x10, x9, x9
  32'hffd5_0513,  // 30 addi x10, x10, -3
  32'h0005_1463,  // 34 bne  x10, x0, +8 (taken)
  32'h7ff0_0593,  // 38 addi x11, x0, 0x7ff (skipped)
  32'h0095_0463,  // 3c beq  x10, x9, +8 (not taken)
  32'h00c0_066f,  // 40 jal  x12, +12
  32'h0010_0593,  // 44 addi x11, x0, 1 (skipped)
  32'h0020_0593,  // 48 addi x11, x0, 2 (skipped)
  32'h0116_06e7,  // 4c jalr x13, 0x11(x12)
  32'h0030_0593,  // 50 addi x11, x0, 3 (skipped)
  32'h0000_a703,  // 54 lw   x14, 0(x1)
  32'h0000_0000,  // 58 all-zero word
  32'h00d6_07b3,  // 5c add  x15, x12, x13
  32'h0000_006f   // 60 jal  x0, 0
};

localparam retire_t EXP [RET_LEN] = '{
  {32'h0000_0000, 5'd1,  1'b1, 32'h0000_0005, 1'b0},
  {32'h0000_0004, 5'd2,  1'b1, 32'h8000_0000, 1'b0},
  {32'h0000_0008, 5'd3,  1'b1, 32'h0000_1008, 1'b0},
  {32'h0000_000c, 5'd4,  1'b1, 32'h8000_0005, 1'b0},
  {32'h0000_0010, 5'd5,  1'b1, 32'hfc00_0000, 1'b0},
  {32'h0000_0014, 5'd6,  1'b1, 32'h0000_0001, 1'b0},
  {32'h0000_0018, 5'd7,  1'b1, 32'h8000_0000, 1'b0},
  {32'h0000_001c, 5'd0,  1'b1, 32'h0000_000c, 1'b0},
  {32'h0000_0020, 5'd8,  1'b1, 32'h0000_0005, 1'b0},
  {32'h0000_0024, 5'd9,  1'b1, 32'h0000_0006, 1'b0},
  {32'h0000_0028, 5'd9,  1'b1, 32'h0000_0008, 1'b0},
  {32'h0000_002c, 5'd10, 1'b1, 32'h0000_0010, 1'b0},
  {32'h0000_0030, 5'd10, 1'b1, 32'h0000_000d, 1'b0},
  {32'h0000_0034, 5'd0,  1'b0, 32'h0000_0000, 1'b0},
  {32'h0000_003c, 5'd0,  1'b0, 32'h0000_0000, 1'b0},
  {32'h0000_0040, 5'd12, 1'b1, 32'h0000_0044, 1'b0},
  {32'h0000_004c, 5'd13, 1'b1, 32'h0000_0050, 1'b0},
  {32'h0000_0054, 5'd0,  1'b0, 32'h0000_a703, 1'b1},
  {32'h0000_0058, 5'd0,  1'b0, 32'h0000_0000, 1'b1},
  {32'h0000_005c, 5'd15, 1'b1, 32'h0000_0094, 1'b0},
  {32'h0000_0060, 5'd0,  1'b1, 32'h0000_0064, 1'b0},
  {32'h0000_0060, 5'd0,  1'b1, 32'h0000_0064, 1'b0}
};

// ==== tests/tb_rv_core.sv ====
// Testbench for rv_core: plays the fetch source, applies retire back-pressure and checks retires
`timescale 1ns/100ps
module tb_rv_core import rv_core_pkg::*; ();

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              we;
    logic [XLEN-1:0]   data;
    logic              trap;
  } retire_t;

  `include "tb_program.svh"

  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = RET_LEN * 20 + RESET_CYCLES;

  logic              clk = 1'b0;
  logic              rst_i;
  logic              fetch_valid_i;
  logic [XLEN-1:0]   fetch_instr_i;
  logic              fetch_ready_o;
  logic              jump_o;
  logic [XLEN-1:0]   jump_pc_o;
  logic              retire_valid_o;
  logic [XLEN-1:0]   retire_pc_o;
  logic [REG_AW-1:0] retire_rd_o;
  logic              retire_we_o;
  logic [XLEN-1:0]   retire_data_o;
  logic              retire_trap_o;
  logic              retire_ready_i;

  logic [XLEN-1:0]   fetch_pc;
  logic [XLEN-1:0]   jump_target;
  logic              take_jump;
  logic              take_fetch;
  logic              timed_out;
  int                errors;
  int                ret_idx;
  int                cycles;

  rv_core DUT (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_ready_o  (fetch_ready_o),
    .jump_o         (jump_o),
    .jump_pc_o      (jump_pc_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_data_o  (retire_data_o),
    .retire_trap_o  (retire_trap_o),
    .retire_ready_i (retire_ready_i)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h at retire %0d", name, got, want, ret_idx);
    end
  endtask

  task automatic check_retire(input int n);
    retire_t want;
    want = EXP[n];
    check_value("retire_pc_o", retire_pc_o, want.pc);
    check_value("retire_we_o", 32'(retire_we_o), 32'(want.we));
    check_value("retire_trap_o", 32'(retire_trap_o), 32'(want.trap));
    if (want.we) begin
      check_value("retire_rd_o", 32'(retire_rd_o), 32'(want.rd));
    end
    if (want.we || want.trap) begin
      check_value("retire_data_o", retire_data_o, want.data);
    end
  endtask

  // Fetch source follows its own PC; sink drops ready one cycle in four
  task automatic drive_inputs();
    int idx;
    idx = int'(fetch_pc[31:2]);
    if (idx < PROG_LEN) begin
      fetch_valid_i = 1'b1;
      fetch_instr_i = PROG[idx];
    end else begin
      fetch_valid_i = 1'b0;
      fetch_instr_i = '0;
    end
    retire_ready_i = ($urandom() % 4) != 0;
  endtask

  initial begin
    void'($urandom(11681));
    rst_i          = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_instr_i  = '0;
    retire_ready_i = 1'b0;
    fetch_pc       = RESET_PC;
    take_jump      = 1'b0;
    take_fetch     = 1'b0;
    jump_target    = '0;
    timed_out      = 1'b0;
    errors         = 0;
    ret_idx        = 0;
    cycles         = 0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
      check_value("jump_o", 32'(jump_o), 32'd0);
      check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
    end
    rst_i = 1'b0;

    while (ret_idx < RET_LEN && !timed_out) begin
      drive_inputs();
      #1;
      // Handshakes seen here are the ones taken at the coming rising edge
      take_jump   = jump_o;
      jump_target = jump_pc_o;
      take_fetch  = fetch_valid_i && fetch_ready_o;
      if (retire_valid_o && retire_ready_i) begin
        check_retire(ret_idx);
        ret_idx++;
      end
      @(posedge clk);
      if (take_jump) begin
        fetch_pc = jump_target;
      end else if (take_fetch) begin
        fetch_pc = fetch_pc + 32'd4;
      end
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
      end
      @(negedge clk);
    end

    if (timed_out) begin
      errors++;
      $display("Timeout: no progress after %0d cycles, waiting for retire %0d", cycles, ret_idx);
    end
    $display("Retires checked: %0d of %0d, errors: %0d", ret_idx, RET_LEN, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
